/* Makefile */
# Verilator build and run of the packet slot buffer testbench

VERILATOR ?= verilator
TOP       ?= pkt_core_sys_tb
FILELIST  ?= pkt_core_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* credit_fifo.sv */
// Credit-returning input queue
`timescale 1ns/10ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     logic_clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     pop,
  output logic     out_valid,
  output payload_t out_data,
  output logic     credit
);

  payload_t                   mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_pop;

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign do_pop    = pop && out_valid;

  // One credit back to the sender per word taken
  assign credit = do_pop;

  always_ff @(posedge logic_clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sender holds back once its credits are spent
  assert property (@(posedge logic_clk) disable iff (rst)
    in_valid |-> (count < DEPTH) || do_pop)
    else $error("credit_fifo: push into a full queue");

endmodule

/* pkt_buffer.sv */
// Shared packet memory with round-robin access
`timescale 1ns/10ps

module pkt_buffer (
  input  logic                           logic_clk,
  input  logic                           rst,
  input  logic                           wr_req,
  input  logic [pkt_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [pkt_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                           rd_req,
  input  logic [pkt_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                           wr_gnt,
  output logic                           rd_gnt,
  output logic [pkt_pkg::DATA_WIDTH-1:0] rd_data
);

  logic [pkt_pkg::DATA_WIDTH-1:0] ram [pkt_pkg::SLOT_COUNT * pkt_pkg::SLOT_WORDS];
  logic                           last_wr;

  // On contention the side that did not win last time goes first
  assign wr_gnt = wr_req && (!rd_req || !last_wr);
  assign rd_gnt = rd_req && (!wr_req || last_wr);

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      last_wr <= 1'b0;
    end else if (wr_gnt) begin
      last_wr <= 1'b1;
    end else if (rd_gnt) begin
      last_wr <= 1'b0;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (wr_gnt) begin
      ram[wr_addr] <= wr_data;
    end
    if (rd_gnt) begin
      rd_data <= ram[rd_addr];
    end
  end

  // Both DMAs hold a request and its address until granted
  assert property (@(posedge logic_clk) disable iff (rst)
    wr_req && !wr_gnt |=> wr_req && $stable(wr_addr))
    else $error("pkt_buffer: write request dropped before grant");

  assert property (@(posedge logic_clk) disable iff (rst)
    rd_req && !rd_gnt |=> rd_req && $stable(rd_addr))
    else $error("pkt_buffer: read request dropped before grant");

endmodule

/* pkt_core_sys.f */
pkt_pkg.sv
credit_fifo.sv
slot_pool.sv
rx_dma.sv
tx_dma.sv
pkt_buffer.sv
pkt_core_sys.sv
tb_clk_gen.sv
pkt_core_sys_tb.sv

/* pkt_core_sys.sv */
// Packet slot buffer top level
`timescale 1ns/10ps

module pkt_core_sys (
  input  logic                           logic_clk,
  input  logic                           rst,
  input  logic [pkt_pkg::DATA_WIDTH-1:0] rx_data,
  input  logic                           rx_last,
  input  logic                           rx_valid,
  output logic                           rx_credit,
  input  logic [pkt_pkg::TAG_WIDTH-1:0]  tx_req_tag,
  input  logic [pkt_pkg::LEN_WIDTH-1:0]  tx_req_len,
  input  logic                           tx_req_valid,
  output logic                           tx_req_credit,
  output logic [pkt_pkg::DATA_WIDTH-1:0] tx_data,
  output logic                           tx_last,
  output logic                           tx_valid,
  input  logic                           tx_credit,
  output logic [pkt_pkg::TAG_WIDTH-1:0]  rx_status_tag,
  output logic [pkt_pkg::LEN_WIDTH-1:0]  rx_status_len,
  output logic                           rx_status_valid,
  output logic [pkt_pkg::TAG_WIDTH-1:0]  tx_status_tag,
  output logic                           tx_status_valid
);

  pkt_pkg::stream_word_t          rx_in_word;
  pkt_pkg::stream_word_t          rx_word;
  logic                           rx_word_valid;
  logic                           rx_word_pop;
  pkt_pkg::tx_desc_t              tx_in_desc;
  pkt_pkg::tx_desc_t              desc;
  logic                           desc_valid;
  logic                           desc_pop;
  logic                           alloc;
  logic                           slot_avail;
  logic [pkt_pkg::TAG_WIDTH-1:0]  slot_tag;
  logic                           release_valid;
  logic [pkt_pkg::TAG_WIDTH-1:0]  release_tag;
  logic                           wr_req;
  logic                           wr_gnt;
  logic [pkt_pkg::ADDR_WIDTH-1:0] wr_addr;
  logic [pkt_pkg::DATA_WIDTH-1:0] wr_data;
  logic                           rd_req;
  logic                           rd_gnt;
  logic [pkt_pkg::ADDR_WIDTH-1:0] rd_addr;
  logic [pkt_pkg::DATA_WIDTH-1:0] rd_data;

  assign rx_in_word = '{data: rx_data, last: rx_last};
  assign tx_in_desc = '{tag: tx_req_tag, len: tx_req_len};

  credit_fifo #(
    .payload_t(pkt_pkg::stream_word_t),
    .DEPTH    (pkt_pkg::RX_CREDITS)
  ) i_rx_fifo (
    .logic_clk(logic_clk), .rst(rst),
    .in_valid (rx_valid), .in_data(rx_in_word), .pop(rx_word_pop),
    .out_valid(rx_word_valid), .out_data(rx_word), .credit(rx_credit)
  );

  credit_fifo #(
    .payload_t(pkt_pkg::tx_desc_t),
    .DEPTH    (pkt_pkg::RX_CREDITS)
  ) i_tx_req_fifo (
    .logic_clk(logic_clk), .rst(rst),
    .in_valid (tx_req_valid), .in_data(tx_in_desc), .pop(desc_pop),
    .out_valid(desc_valid), .out_data(desc), .credit(tx_req_credit)
  );

  slot_pool i_slot_pool (
    .logic_clk(logic_clk), .rst(rst), .alloc(alloc),
    .release_valid(release_valid), .release_tag(release_tag),
    .slot_avail(slot_avail), .slot_tag(slot_tag)
  );

  rx_dma i_rx_dma (
    .logic_clk(logic_clk), .rst(rst),
    .word_valid(rx_word_valid), .word(rx_word), .word_pop(rx_word_pop),
    .slot_avail(slot_avail), .slot_tag(slot_tag), .alloc(alloc),
    .mem_gnt(wr_gnt), .mem_req(wr_req), .mem_addr(wr_addr), .mem_wdata(wr_data),
    .status_valid(rx_status_valid), .status_tag(rx_status_tag),
    .status_len(rx_status_len)
  );

  tx_dma i_tx_dma (
    .logic_clk(logic_clk), .rst(rst),
    .desc_valid(desc_valid), .desc(desc), .desc_pop(desc_pop),
    .mem_gnt(rd_gnt), .mem_rdata(rd_data), .mem_req(rd_req), .mem_addr(rd_addr),
    .out_credit(tx_credit), .out_data(tx_data), .out_last(tx_last), .out_valid(tx_valid),
    .release_valid(release_valid), .release_tag(release_tag),
    .status_valid(tx_status_valid), .status_tag(tx_status_tag)
  );

  pkt_buffer i_pkt_buffer (
    .logic_clk(logic_clk), .rst(rst),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_gnt(wr_gnt),
    .rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt), .rd_data(rd_data)
  );

endmodule

/* pkt_core_sys_tb.sv */
// Packet slot buffer testbench
`timescale 1ns/10ps

module pkt_core_sys_tb;

  localparam int NUM_PKTS = 49;

  logic                           clk;
  logic                           rst;
  logic [pkt_pkg::DATA_WIDTH-1:0] rx_data;
  logic                           rx_last;
  logic                           rx_valid;
  logic                           rx_credit;
  logic [pkt_pkg::TAG_WIDTH-1:0]  tx_req_tag;
  logic [pkt_pkg::LEN_WIDTH-1:0]  tx_req_len;
  logic                           tx_req_valid;
  logic                           tx_req_credit;
  logic [pkt_pkg::DATA_WIDTH-1:0] tx_data;
  logic                           tx_last;
  logic                           tx_valid;
  logic                           tx_credit;
  logic [pkt_pkg::TAG_WIDTH-1:0]  rx_status_tag;
  logic [pkt_pkg::LEN_WIDTH-1:0]  rx_status_len;
  logic                           rx_status_valid;
  logic [pkt_pkg::TAG_WIDTH-1:0]  tx_status_tag;
  logic                           tx_status_valid;

  // Reference model state
  int                seed;
  int                cycles;
  int                limit;
  int                total_words;
  int                first_fill_words;
  int                pkt_len [NUM_PKTS];
  int                free_list [$];
  logic [63:0]       slot_mem [pkt_pkg::SLOT_COUNT * pkt_pkg::SLOT_WORDS];
  int                slot_len [pkt_pkg::SLOT_COUNT];
  logic [63:0]       sent_words [$];
  int                sent_lens [$];
  logic [64:0]       rx_send [$];
  pkt_pkg::tx_desc_t desc_send [$];
  int                ready [$];
  int                issued [$];
  int                tx_idx;
  int                rx_count;
  int                tx_count;
  int                released_tag;
  int                rx_credits;
  int                desc_credits;
  int                rx_pulses;
  int                desc_pulses;
  int                out_credits;
  int                credits_owed;
  int                credit_wait;
  logic              auto_tx;

  tb_clk_gen i_tb_clk_gen (.clk(clk), .rst(rst));

  pkt_core_sys i_pkt_core_sys (.logic_clk(clk), .*);

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task automatic check_idle(input string name);
    check_value({name, " rx_credit"}, 0, rx_credit);
    check_value({name, " tx_req_credit"}, 0, tx_req_credit);
    check_value({name, " tx_valid"}, 0, tx_valid);
    check_value({name, " rx_status_valid"}, 0, rx_status_valid);
    check_value({name, " tx_status_valid"}, 0, tx_status_valid);
  endtask

  task automatic queue_packet(input int len);
    logic [63:0] data;
    for (int i = 0; i < len; i++) begin
      data = {$random(seed), $random(seed)};
      rx_send.push_back({i == len - 1, data});
      sent_words.push_back(data);
    end
    sent_lens.push_back(len);
  endtask

  task automatic issue_descriptor(input int tag);
    pkt_pkg::tx_desc_t desc;
    desc.tag = tag;
    desc.len = slot_len[tag];
    desc_send.push_back(desc);
    issued.push_back(tag);
  endtask

  task automatic sample_outputs();
    int   tag;
    logic last_beat;
    last_beat = 1'b0;
    rx_credits += rx_credit;
    rx_pulses += rx_credit;
    desc_credits += tx_req_credit;
    desc_pulses += tx_req_credit;
    if (rx_credits > pkt_pkg::RX_CREDITS || desc_credits > pkt_pkg::RX_CREDITS) begin
      abort_run("credit pulse returned for an input beat that was never sent");
    end
    if (rx_status_valid) begin
      if (free_list.size() == 0 || sent_lens.size() == 0) begin
        abort_run("receive status with no free slot or no packet pending in the model");
      end else begin
        tag = free_list.pop_front();
        check_value("rx_status_tag", tag, rx_status_tag);
        check_value("rx_status_len", sent_lens[0], rx_status_len);
        slot_len[tag] = sent_lens.pop_front();
        for (int i = 0; i < slot_len[tag]; i++) begin
          slot_mem[tag * pkt_pkg::SLOT_WORDS + i] = sent_words.pop_front();
        end
        ready.push_back(tag);
        rx_count++;
      end
    end
    if (tx_valid) begin
      if (out_credits == 0) begin
        abort_run("tx_valid beat sent while the DUT held no output credit");
      end else if (issued.size() == 0) begin
        abort_run("tx_valid beat with no transmit descriptor outstanding");
      end else begin
        tag = issued[0];
        last_beat = (tx_idx == slot_len[tag] - 1);
        out_credits--;
        credits_owed++;
        check_value("tx_data", slot_mem[tag * pkt_pkg::SLOT_WORDS + tx_idx], tx_data);
        check_value("tx_last", last_beat, tx_last);
        tx_idx = last_beat ? 0 : tx_idx + 1;
      end
    end
    // Status only with the final beat of a packet
    check_value("tx_status_valid", last_beat, tx_status_valid);
    if (tx_status_valid) begin
      if (issued.size() == 0) begin
        abort_run("transmit status with no transmit descriptor outstanding");
      end else begin
        check_value("tx_status_tag", issued[0], tx_status_tag);
        // Released slot goes to the back of the free list
        free_list.push_back(issued.pop_front());
        tx_count++;
      end
    end
  endtask

  task automatic drive_inputs();
    int                idx;
    pkt_pkg::tx_desc_t desc;
    tx_credit = 1'b0;
    if (credits_owed > 0 && credit_wait == 0) begin
      tx_credit = 1'b1;
      credits_owed--;
      out_credits++;
      credit_wait = $unsigned($random(seed)) % 8;
    end else if (credit_wait > 0) begin
      credit_wait--;
    end
    if (auto_tx && ready.size() > 0 && $unsigned($random(seed)) % 3 == 0) begin
      idx = $unsigned($random(seed)) % ready.size();
      issue_descriptor(ready[idx]);
      ready.delete(idx);
    end
    rx_valid = 1'b0;
    if (rx_send.size() > 0 && rx_credits > 0 && ($random(seed) & 3) != 0) begin
      {rx_last, rx_data} = rx_send.pop_front();
      rx_valid = 1'b1;
      rx_credits--;
    end
    tx_req_valid = 1'b0;
    if (desc_send.size() > 0 && desc_credits > 0) begin
      desc = desc_send.pop_front();
      tx_req_tag = desc.tag;
      tx_req_len = desc.len;
      tx_req_valid = 1'b1;
      desc_credits--;
    end
  endtask

  // Outputs come from registers only, so sampling before driving is safe
  task automatic step_cycle();
    @(negedge clk);
    cycles++;
    if (cycles > limit) begin
      abort_run($sformatf("timeout, the run went past its limit of %0d cycles", limit));
    end else begin
      sample_outputs();
      drive_inputs();
    end
  endtask

  initial begin
    rx_data = '0;
    rx_last = 1'b0;
    rx_valid = 1'b0;
    tx_req_tag = '0;
    tx_req_len = '0;
    tx_req_valid = 1'b0;
    tx_credit = 1'b0;
    seed = 86340;
    cycles = 0;
    total_words = 0;
    first_fill_words = 0;
    tx_idx = 0;
    rx_count = 0;
    tx_count = 0;
    rx_credits = pkt_pkg::RX_CREDITS;
    desc_credits = pkt_pkg::RX_CREDITS;
    rx_pulses = 0;
    desc_pulses = 0;
    out_credits = pkt_pkg::TX_CREDITS;
    credits_owed = 0;
    credit_wait = 0;
    auto_tx = 1'b0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      pkt_len[p] = 1 + $unsigned($random(seed)) % pkt_pkg::SLOT_WORDS;
      total_words += pkt_len[p];
    end
    limit = total_words * 20 + 1000;
    for (int s = 0; s < pkt_pkg::SLOT_COUNT; s++) begin
      free_list.push_back(s);
    end

    // Two cycles inside reset and three after it
    @(posedge clk);
    for (int i = 0; i < 5; i++) begin
      step_cycle();
      check_idle("reset_state");
    end

    // Fill every slot, then a ninth packet has to wait for a release
    for (int p = 0; p < pkt_pkg::SLOT_COUNT; p++) begin
      queue_packet(pkt_len[p]);
      first_fill_words += pkt_len[p];
    end
    while (rx_count < pkt_pkg::SLOT_COUNT) step_cycle();
    queue_packet(pkt_len[pkt_pkg::SLOT_COUNT]);
    repeat (40) step_cycle();
    // No word of the ninth packet is taken while the pool is empty
    check_value("pool_exhausted_hold", first_fill_words, rx_pulses);
    released_tag = ready.pop_front();
    issue_descriptor(released_tag);
    while (rx_count < pkt_pkg::SLOT_COUNT + 1) step_cycle();

    // Mixed traffic with random transmit order
    auto_tx = 1'b1;
    for (int p = pkt_pkg::SLOT_COUNT + 1; p < NUM_PKTS; p++) begin
      queue_packet(pkt_len[p]);
    end
    while (rx_count < NUM_PKTS || tx_count < NUM_PKTS) step_cycle();
    while (credits_owed > 0) step_cycle();
    check_value("rx_credit_pulses", total_words, rx_pulses);
    check_value("tx_req_credit_pulses", NUM_PKTS, desc_pulses);
    repeat (5) begin
      step_cycle();
      check_idle("final_idle");
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* pkt_pkg.sv */
// Packet slot buffer definitions
package pkt_pkg;

  // Word and slot geometry
  localparam int DATA_WIDTH = 64;
  localparam int SLOT_COUNT = 8;
  localparam int SLOT_WORDS = 16;
  localparam int TAG_WIDTH  = 3;
  localparam int LEN_WIDTH  = 5;
  localparam int OFFS_WIDTH = 4;

  // Tag in the upper bits, word offset in the lower
  localparam int ADDR_WIDTH = TAG_WIDTH + OFFS_WIDTH;

  // Flow control
  localparam int RX_CREDITS   = 4;
  localparam int TX_CREDITS   = 4;
  localparam int CREDIT_WIDTH = 3;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } stream_word_t;

  typedef struct packed {
    logic [TAG_WIDTH-1:0] tag;
    logic [LEN_WIDTH-1:0] len;
  } tx_desc_t;

endpackage

/* rx_dma.sv */
// Receive DMA into packet slots
`timescale 1ns/10ps

module rx_dma (
  input  logic                           logic_clk,
  input  logic                           rst,
  input  logic                           word_valid,
  input  pkt_pkg::stream_word_t          word,
  input  logic                           slot_avail,
  input  logic [pkt_pkg::TAG_WIDTH-1:0]  slot_tag,
  input  logic                           mem_gnt,
  output logic                           word_pop,
  output logic                           alloc,
  output logic                           mem_req,
  output logic [pkt_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [pkt_pkg::DATA_WIDTH-1:0] mem_wdata,
  output logic                           status_valid,
  output logic [pkt_pkg::TAG_WIDTH-1:0]  status_tag,
  output logic [pkt_pkg::LEN_WIDTH-1:0]  status_len
);

  logic                          busy;
  logic [pkt_pkg::TAG_WIDTH-1:0] tag_q;
  logic [pkt_pkg::TAG_WIDTH-1:0] cur_tag;
  logic [pkt_pkg::LEN_WIDTH-1:0] offset;

  // First word of a packet uses the pool head directly
  assign cur_tag = busy ? tag_q : slot_tag;

  assign mem_req   = word_valid && (busy || slot_avail);
  assign mem_addr  = {cur_tag, offset[pkt_pkg::OFFS_WIDTH-1:0]};
  assign mem_wdata = word.data;
  assign word_pop  = mem_gnt;
  assign alloc     = mem_gnt && !busy;

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      busy         <= 1'b0;
      offset       <= '0;
      status_valid <= 1'b0;
    end else begin
      status_valid <= mem_gnt && word.last;
      if (mem_gnt) begin
        if (word.last) begin
          busy   <= 1'b0;
          offset <= '0;
        end else begin
          busy   <= 1'b1;
          offset <= offset + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (mem_gnt) begin
      tag_q <= cur_tag;
    end
    if (mem_gnt && word.last) begin
      status_tag <= cur_tag;
      status_len <= offset + 1'b1;
    end
  end

  // A packet never runs past the end of its slot
  assert property (@(posedge logic_clk) disable iff (rst)
    mem_gnt && !word.last |-> offset < pkt_pkg::SLOT_WORDS - 1)
    else $error("rx_dma: packet longer than a slot");

endmodule

/* slot_pool.sv */
// Free slot list
`timescale 1ns/10ps

module slot_pool (
  input  logic                          logic_clk,
  input  logic                          rst,
  input  logic                          alloc,
  input  logic                          release_valid,
  input  logic [pkt_pkg::TAG_WIDTH-1:0] release_tag,
  output logic                          slot_avail,
  output logic [pkt_pkg::TAG_WIDTH-1:0] slot_tag
);

  logic [pkt_pkg::TAG_WIDTH-1:0] free_q [pkt_pkg::SLOT_COUNT];
  logic [pkt_pkg::TAG_WIDTH-1:0] wr_ptr;
  logic [pkt_pkg::TAG_WIDTH-1:0] rd_ptr;
  logic [pkt_pkg::TAG_WIDTH:0]   count;
  logic                          fill_done;
  logic                          push;
  logic [pkt_pkg::TAG_WIDTH-1:0] push_tag;

  // During the initial fill the write pointer is the slot number
  assign push     = !fill_done || release_valid;
  assign push_tag = fill_done ? release_tag : wr_ptr;

  assign slot_avail = fill_done && (count != '0);
  assign slot_tag   = free_q[rd_ptr];

  always_ff @(posedge logic_clk) begin
    if (!rst && push) begin
      free_q[wr_ptr] <= push_tag;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      fill_done <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (alloc) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (!fill_done && int'(wr_ptr) == pkt_pkg::SLOT_COUNT - 1) begin
        fill_done <= 1'b1;
      end
      case ({push, alloc})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge logic_clk) disable iff (rst) alloc |-> slot_avail)
    else $error("slot_pool: allocation from an empty pool");

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Released on a falling edge like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* tx_dma.sv */
// Transmit DMA out of packet slots
`timescale 1ns/10ps

module tx_dma (
  input  logic                           logic_clk,
  input  logic                           rst,
  input  logic                           desc_valid,
  input  pkt_pkg::tx_desc_t              desc,
  input  logic                           mem_gnt,
  input  logic [pkt_pkg::DATA_WIDTH-1:0] mem_rdata,
  input  logic                           out_credit,
  output logic                           desc_pop,
  output logic                           mem_req,
  output logic [pkt_pkg::ADDR_WIDTH-1:0] mem_addr,
  output logic [pkt_pkg::DATA_WIDTH-1:0] out_data,
  output logic                           out_last,
  output logic                           out_valid,
  output logic                           release_valid,
  output logic [pkt_pkg::TAG_WIDTH-1:0]  release_tag,
  output logic                           status_valid,
  output logic [pkt_pkg::TAG_WIDTH-1:0]  status_tag
);

  logic [pkt_pkg::TAG_WIDTH-1:0]    cur_tag;
  logic [pkt_pkg::OFFS_WIDTH-1:0]   rd_offs;
  logic [pkt_pkg::LEN_WIDTH-1:0]    remaining;
  logic [pkt_pkg::CREDIT_WIDTH-1:0] credit_cnt;

  // Next descriptor is taken once all reads of the last one are granted
  assign desc_pop = desc_valid && (remaining == '0);

  // Credit is reserved at the grant, the beat follows one cycle later
  assign mem_req  = (remaining != '0) && (credit_cnt != '0);
  assign mem_addr = {cur_tag, rd_offs};
  assign out_data = mem_rdata;

  // cur_tag is replaced no earlier than the end of the last beat
  assign release_valid = out_valid && out_last;
  assign release_tag   = cur_tag;
  assign status_valid  = release_valid;
  assign status_tag    = cur_tag;

  always_ff @(posedge logic_clk) begin
    if (rst) begin
      remaining  <= '0;
      rd_offs    <= '0;
      credit_cnt <= pkt_pkg::CREDIT_WIDTH'(pkt_pkg::TX_CREDITS);
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
    end else begin
      out_valid <= mem_gnt;
      out_last  <= mem_gnt && (remaining == 1'b1);
      if (desc_pop) begin
        remaining <= desc.len;
        rd_offs   <= '0;
      end else if (mem_gnt) begin
        remaining <= remaining - 1'b1;
        rd_offs   <= rd_offs + 1'b1;
      end
      case ({mem_gnt, out_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge logic_clk) begin
    if (desc_pop) begin
      cur_tag <= desc.tag;
    end
  end

  assert property (@(posedge logic_clk) disable iff (rst)
    out_valid |-> $past(credit_cnt) != '0)
    else $error("tx_dma: beat sent without an output credit");

endmodule
